//--- Bender.yml
package:
  name: sorted_lists

sources:
  - logic/sorted_lists_pkg.sv
  - logic/list_table.sv
  - logic/table_arbiter.sv
  - logic/update_engine.sv
  - logic/list_sorter.sv
  - logic/query_engine.sv
  - logic/sorted_lists.sv
  - target: test
    files:
      - verif/sorted_lists_tb.sv

//--- logic/list_sorter.sv
`timescale 1ns/1ns
// Sorts one list by ascending key, invalid entries last
// Four-entry network of five compare-exchanges, split over one register
// out_* follow in_* by one cycle
module list_sorter (
  input  logic                          clk,
  input  sorted_lists_pkg::list_state_t in_state,
  input  logic                          in_vld,
  output sorted_lists_pkg::list_state_t out_state,
  output sorted_lists_pkg::count_t      out_count,
  output logic                          out_vld
);

  sorted_lists_pkg::list_state_t s1_d;
  sorted_lists_pkg::list_state_t s1_q;

  // True when a must move behind b, an invalid entry ranks above every key
  function automatic logic after(sorted_lists_pkg::entry_t a, sorted_lists_pkg::entry_t b);
    return (!a.vld && b.vld) || (a.vld && b.vld && (a.key > b.key));
  endfunction

  // Swap slots lo and hi when out of order
  function automatic sorted_lists_pkg::list_state_t cas(sorted_lists_pkg::list_state_t s,
                                                        int lo, int hi);
    sorted_lists_pkg::list_state_t r;
    r = s;
    if (after(s.e[lo], s.e[hi])) begin
      r.e[lo] = s.e[hi];
      r.e[hi] = s.e[lo];
    end
    return r;
  endfunction

  // First two layers, pairs then cross pairs
  always_comb begin
    s1_d = cas(in_state, 0, 1);
    s1_d = cas(s1_d, 2, 3);
    s1_d = cas(s1_d, 0, 2);
    s1_d = cas(s1_d, 1, 3);
  end

  always_ff @(posedge clk) begin
    s1_q    <= s1_d;
    out_vld <= in_vld;
  end

  // Ends are settled, only the middle pair is left
  assign out_state = cas(s1_q, 1, 2);
  assign out_count = sorted_lists_pkg::count_valid(s1_q);

endmodule

//--- logic/list_table.sv
`timescale 1ns/1ns
// Single-port table of list states, one word per list id
// Swept to empty after rst, one address per cycle; busy is high meanwhile
// Reads return data on the next cycle; a write leaves rd_data as it was
module list_table (
  input  logic                          clk,
  input  logic                          rst,
  input  sorted_lists_pkg::tbl_req_t    req,
  input  logic                          en,
  output sorted_lists_pkg::list_state_t rd_data,
  output logic                          busy
);

  sorted_lists_pkg::list_state_t mem [sorted_lists_pkg::num_lists];
  sorted_lists_pkg::id_t         sweep_q;

  // Sweep counter walks every address once
  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b1;
      sweep_q <= '0;
    end else if (busy) begin
      sweep_q <= sweep_q + 1'b1;
      if (sweep_q == sorted_lists_pkg::id_t'(sorted_lists_pkg::num_lists - 1)) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    // Sweep write has priority, engines are held off anyway
    if (busy) begin
      mem[sweep_q] <= '0;
    end else if (en && req.we) begin
      mem[req.addr] <= req.wdata;
    end
    if (en && !req.we) begin
      rd_data <= mem[req.addr];
    end
  end

  // Arbiter must keep both engines off the table until the sweep ends
  assert property (@(posedge clk) disable iff (rst) busy |-> !en)
    else $error("table access during reset sweep");

endmodule

//--- logic/query_engine.sv
`timescale 1ns/1ns
// Reads one list, sorts it and returns the entry at the requested level
// One query at a time over a four-phase req/ack handshake
// Level not below the count gives error with key and size zero; never writes
module query_engine (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          qry_req,
  input  sorted_lists_pkg::qry_cmd_t    qry_cmd,
  output logic                          qry_ack,
  output sorted_lists_pkg::qry_rsp_t    qry_rsp,
  output logic                          mem_req,
  input  logic                          mem_gnt,
  output sorted_lists_pkg::tbl_req_t    tbl_req,
  input  sorted_lists_pkg::list_state_t rd_data
);

  typedef enum logic [2:0] {
    st_idle,
    st_wait_gnt,
    st_load,
    st_sort,
    st_ack
  } state_t;

  state_t                        state_q;
  sorted_lists_pkg::qry_cmd_t    cmd_q;
  sorted_lists_pkg::qry_rsp_t    rsp_d;
  sorted_lists_pkg::qry_rsp_t    rsp_q;
  sorted_lists_pkg::list_state_t sort_state;
  sorted_lists_pkg::count_t      sort_count;
  sorted_lists_pkg::entry_t      sel;
  logic                          sort_vld;
  logic                          in_range;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle:     if (qry_req) state_q <= st_wait_gnt;
        // Read issued in the grant cycle
        st_wait_gnt: if (mem_gnt) state_q <= st_load;
        st_load:     state_q <= st_sort;
        st_sort:     if (sort_vld) state_q <= st_ack;
        st_ack:      if (!qry_req) state_q <= st_idle;
        default:     state_q <= st_idle;
      endcase
    end
  end

  // Pick the level out of the sorted list
  always_comb begin
    sel        = sort_state.e[sorted_lists_pkg::slot_t'(cmd_q.level)];
    in_range   = (cmd_q.level < sort_count);
    rsp_d.key  = in_range ? sel.key : '0;
    rsp_d.size = in_range ? sel.size : '0;
    rsp_d.error = !in_range;
    rsp_d.count = sort_count;
  end

  always_ff @(posedge clk) begin
    if ((state_q == st_idle) && qry_req) begin
      cmd_q <= qry_cmd;
    end
    if ((state_q == st_sort) && sort_vld) begin
      rsp_q <= rsp_d;
    end
  end

  // Table only needed for the single read
  assign mem_req = (state_q == st_wait_gnt);
  assign tbl_req = '{we: 1'b0, addr: cmd_q.id, wdata: '0};
  assign qry_ack = (state_q == st_ack);
  assign qry_rsp = rsp_q;

  // Read data is valid in st_load
  list_sorter sorter0 (
    .clk       (clk),
    .in_state  (rd_data),
    .in_vld    (state_q == st_load),
    .out_state (sort_state),
    .out_count (sort_count),
    .out_vld   (sort_vld)
  );

endmodule

//--- logic/sorted_lists.sv
`timescale 1ns/1ns
// Sorted list engine with one shared table for updates and queries
// Both command ports are four-phase req/ack, one command in flight each
// Commands are held off for num_lists cycles after rst while the table clears
module sorted_lists (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       upd_req,
  input  sorted_lists_pkg::upd_cmd_t upd_cmd,
  output logic                       upd_ack,
  output sorted_lists_pkg::upd_rsp_t upd_rsp,
  input  logic                       qry_req,
  input  sorted_lists_pkg::qry_cmd_t qry_cmd,
  output logic                       qry_ack,
  output sorted_lists_pkg::qry_rsp_t qry_rsp,
  output logic                       ntf_vld,
  output sorted_lists_pkg::ntf_t     ntf
);

  logic                          upd_mem_req;
  logic                          upd_mem_gnt;
  logic                          qry_mem_req;
  logic                          qry_mem_gnt;
  logic                          tbl_en;
  logic                          tbl_busy;
  sorted_lists_pkg::tbl_req_t    upd_tbl_req;
  sorted_lists_pkg::tbl_req_t    qry_tbl_req;
  sorted_lists_pkg::tbl_req_t    tbl_req;
  // Read data fans out to both engines
  sorted_lists_pkg::list_state_t rd_data;

  update_engine upd_eng0 (
    .clk     (clk),
    .rst     (rst),
    .upd_req (upd_req),
    .upd_cmd (upd_cmd),
    .upd_ack (upd_ack),
    .upd_rsp (upd_rsp),
    .mem_req (upd_mem_req),
    .mem_gnt (upd_mem_gnt),
    .tbl_req (upd_tbl_req),
    .rd_data (rd_data),
    .ntf_vld (ntf_vld),
    .ntf     (ntf)
  );

  query_engine qry_eng0 (
    .clk     (clk),
    .rst     (rst),
    .qry_req (qry_req),
    .qry_cmd (qry_cmd),
    .qry_ack (qry_ack),
    .qry_rsp (qry_rsp),
    .mem_req (qry_mem_req),
    .mem_gnt (qry_mem_gnt),
    .tbl_req (qry_tbl_req),
    .rd_data (rd_data)
  );

  table_arbiter arb0 (
    .clk         (clk),
    .rst         (rst),
    .upd_mem_req (upd_mem_req),
    .qry_mem_req (qry_mem_req),
    .upd_tbl_req (upd_tbl_req),
    .qry_tbl_req (qry_tbl_req),
    .busy        (tbl_busy),
    .upd_mem_gnt (upd_mem_gnt),
    .qry_mem_gnt (qry_mem_gnt),
    .tbl_en      (tbl_en),
    .tbl_req     (tbl_req)
  );

  list_table table0 (
    .clk     (clk),
    .rst     (rst),
    .req     (tbl_req),
    .en      (tbl_en),
    .rd_data (rd_data),
    .busy    (tbl_busy)
  );

endmodule

//--- logic/sorted_lists_pkg.sv
// Sizes, opcodes and bus structs shared by the sorted list engine and its testbench
// The sorter network is wired for list_depth of 4
// level_t is one bit wider than a slot so a query can name a level past the depth
package sorted_lists_pkg;

  // Table geometry and field widths
  localparam int num_lists  = 8;
  localparam int list_depth = 4;
  localparam int key_w      = 16;
  localparam int size_w     = 16;

  typedef logic [$clog2(num_lists)-1:0]  id_t;
  typedef logic [$clog2(list_depth):0]   level_t;
  typedef logic [$clog2(list_depth):0]   count_t;
  typedef logic [$clog2(list_depth)-1:0] slot_t;

  // Update opcodes
  typedef enum logic [1:0] {
    op_clear   = 2'd0,
    op_add     = 2'd1,
    op_delete  = 2'd2,
    op_replace = 2'd3
  } op_t;

  // One slot of a list
  typedef struct packed {
    logic              vld;
    logic [key_w-1:0]  key;
    logic [size_w-1:0] size;
  } entry_t;

  // Whole list as stored in one table word, slots unordered
  typedef struct packed {
    entry_t [list_depth-1:0] e;
  } list_state_t;

  typedef struct packed {
    id_t               id;
    op_t               op;
    logic [key_w-1:0]  key;
    logic [size_w-1:0] size;
  } upd_cmd_t;

  typedef struct packed {
    logic error;
  } upd_rsp_t;

  typedef struct packed {
    id_t    id;
    level_t level;
  } qry_cmd_t;

  typedef struct packed {
    logic [key_w-1:0]  key;
    logic [size_w-1:0] size;
    logic              error;
    count_t            count;
  } qry_rsp_t;

  // Raised when a list goes empty
  typedef struct packed {
    id_t               id;
    logic [key_w-1:0]  key;
    logic [size_w-1:0] size;
  } ntf_t;

  // Table access as issued by an engine
  typedef struct packed {
    logic        we;
    id_t         addr;
    list_state_t wdata;
  } tbl_req_t;

  // Number of valid slots in a list
  function automatic count_t count_valid(list_state_t s);
    count_t n;
    n = '0;
    for (int i = 0; i < list_depth; i++) begin
      n = n + count_t'(s.e[i].vld);
    end
    return n;
  endfunction

endpackage

//--- logic/table_arbiter.sv
`timescale 1ns/1ns
// Round-robin owner of the table between the update and query engines
// An owner keeps the grant as long as it holds mem_req, so a read-modify-write
// is never split; grants are registered and held low while the table sweeps
module table_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       upd_mem_req,
  input  logic                       qry_mem_req,
  input  sorted_lists_pkg::tbl_req_t upd_tbl_req,
  input  sorted_lists_pkg::tbl_req_t qry_tbl_req,
  input  logic                       busy,
  output logic                       upd_mem_gnt,
  output logic                       qry_mem_gnt,
  output logic                       tbl_en,
  output sorted_lists_pkg::tbl_req_t tbl_req
);

  // Set when the query engine was the last one granted
  logic last_qry;
  logic pick_qry;

  // Access goes out only while the owner still requests
  assign tbl_en  = (upd_mem_gnt && upd_mem_req) || (qry_mem_gnt && qry_mem_req);
  assign tbl_req = qry_mem_gnt ? qry_tbl_req : upd_tbl_req;

  // On a tie the engine not served last wins
  assign pick_qry = qry_mem_req && (!upd_mem_req || !last_qry);

  always_ff @(posedge clk) begin
    if (rst) begin
      upd_mem_gnt <= 1'b0;
      qry_mem_gnt <= 1'b0;
      last_qry    <= 1'b0;
    end else if (!tbl_en) begin
      // Owner released or none yet, hand over to whoever waits
      upd_mem_gnt <= !busy && upd_mem_req && !pick_qry;
      qry_mem_gnt <= !busy && pick_qry;
      if (!busy && (upd_mem_req || qry_mem_req)) begin
        last_qry <= pick_qry;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(upd_mem_gnt && qry_mem_gnt))
    else $error("both engines own the table");

  // A grant is only ever the answer to a request seen the cycle before
  assert property (@(posedge clk) disable iff (rst) upd_mem_gnt |-> $past(upd_mem_req))
    else $error("update grant without request");

  assert property (@(posedge clk) disable iff (rst) qry_mem_gnt |-> $past(qry_mem_req))
    else $error("query grant without request");

endmodule

//--- logic/update_engine.sv
`timescale 1ns/1ns
// Read-modify-write sequencer for clear, add, delete and replace
// One command at a time over a four-phase req/ack handshake
// A failed command writes the list back unchanged and sets the error bit
// ntf_vld pulses with upd_ack when a successful update empties the list
module update_engine (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          upd_req,
  input  sorted_lists_pkg::upd_cmd_t    upd_cmd,
  output logic                          upd_ack,
  output sorted_lists_pkg::upd_rsp_t    upd_rsp,
  output logic                          mem_req,
  input  logic                          mem_gnt,
  output sorted_lists_pkg::tbl_req_t    tbl_req,
  input  sorted_lists_pkg::list_state_t rd_data,
  output logic                          ntf_vld,
  output sorted_lists_pkg::ntf_t        ntf
);

  // Read goes out in the grant cycle of st_wait_gnt
  typedef enum logic [2:0] {
    st_idle,
    st_wait_gnt,
    st_exec,
    st_write,
    st_ack
  } state_t;

  state_t                        state_q;
  sorted_lists_pkg::upd_cmd_t    cmd_q;
  sorted_lists_pkg::list_state_t new_state;
  sorted_lists_pkg::list_state_t new_q;
  sorted_lists_pkg::slot_t       free_slot;
  sorted_lists_pkg::slot_t       hit_slot;
  sorted_lists_pkg::ntf_t        ntf_d;
  sorted_lists_pkg::ntf_t        ntf_q;
  logic                          full;
  logic                          found;
  logic                          err;
  logic                          err_q;
  logic                          notify;
  logic                          notify_q;

  // Lowest free slot and the slot holding the command key
  always_comb begin
    free_slot = '0;
    hit_slot  = '0;
    full      = 1'b1;
    found     = 1'b0;
    // Scan downwards so the lowest match is left standing
    for (int i = sorted_lists_pkg::list_depth - 1; i >= 0; i--) begin
      if (!rd_data.e[i].vld) begin
        free_slot = sorted_lists_pkg::slot_t'(i);
        full      = 1'b0;
      end
      if (rd_data.e[i].vld && (rd_data.e[i].key == cmd_q.key)) begin
        hit_slot = sorted_lists_pkg::slot_t'(i);
        found    = 1'b1;
      end
    end
  end

  // Execute on the list as it comes back from the table
  always_comb begin
    new_state = rd_data;
    err       = 1'b0;
    case (cmd_q.op)
      sorted_lists_pkg::op_clear: begin
        new_state = '0;
      end
      sorted_lists_pkg::op_add: begin
        err = full;
        if (!full) begin
          new_state.e[free_slot].vld  = 1'b1;
          new_state.e[free_slot].key  = cmd_q.key;
          new_state.e[free_slot].size = cmd_q.size;
        end
      end
      sorted_lists_pkg::op_delete: begin
        err = !found;
        if (found) begin
          new_state.e[hit_slot] = '0;
        end
      end
      sorted_lists_pkg::op_replace: begin
        err = !found;
        if (found) begin
          new_state.e[hit_slot].size = cmd_q.size;
        end
      end
    endcase

    // Clear always notifies, a delete only when it took the last entry
    notify = !err && ((cmd_q.op == sorted_lists_pkg::op_clear) ||
             ((cmd_q.op == sorted_lists_pkg::op_delete) &&
              (sorted_lists_pkg::count_valid(new_state) == '0)));

    ntf_d.id   = cmd_q.id;
    ntf_d.key  = '0;
    ntf_d.size = '0;
    // Deleted pair travels with the notification
    if (cmd_q.op == sorted_lists_pkg::op_delete) begin
      ntf_d.key  = rd_data.e[hit_slot].key;
      ntf_d.size = rd_data.e[hit_slot].size;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      ntf_vld <= 1'b0;
    end else begin
      ntf_vld <= 1'b0;
      case (state_q)
        st_idle: begin
          if (upd_req) begin
            state_q <= st_wait_gnt;
          end
        end
        st_wait_gnt: begin
          if (mem_gnt) begin
            state_q <= st_exec;
          end
        end
        st_exec: begin
          state_q <= st_write;
        end
        st_write: begin
          state_q <= st_ack;
          ntf_vld <= notify_q;
        end
        st_ack: begin
          // Ack falls on the edge after req drops
          if (!upd_req) begin
            state_q <= st_idle;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // Command and result registers
  always_ff @(posedge clk) begin
    if ((state_q == st_idle) && upd_req) begin
      cmd_q <= upd_cmd;
    end
    if (state_q == st_exec) begin
      new_q    <= new_state;
      err_q    <= err;
      notify_q <= notify;
      ntf_q    <= ntf_d;
    end
  end

  // Table held from the read through the write
  assign mem_req = (state_q == st_wait_gnt) || (state_q == st_exec) || (state_q == st_write);
  assign tbl_req = '{we: (state_q == st_write), addr: cmd_q.id, wdata: new_q};

  assign upd_ack = (state_q == st_ack);
  assign upd_rsp = '{error: err_q};
  assign ntf     = ntf_q;

  // Requester keeps the command stable until it sees ack
  assert property (@(posedge clk) disable iff (rst)
    (upd_req && !upd_ack) |=> (!upd_req || $stable(upd_cmd)))
    else $error("upd_cmd changed while waiting for ack");

endmodule

//--- sources.f
logic/sorted_lists_pkg.sv
logic/list_table.sv
logic/table_arbiter.sv
logic/update_engine.sv
logic/list_sorter.sv
logic/query_engine.sv
logic/sorted_lists.sv
verif/sorted_lists_tb.sv

//--- verif/sorted_lists_tb.sv
`timescale 1ns/1ns
// Table-driven testbench for the sorted list engine
// Each row is one command with its expected response and notification
// An update row marked for overlap runs at the same time as the query row after it
// Such pairs use different ids so that either serial order gives the same result
module sorted_lists_tb;

  // Longest wait in clock cycles for any ack edge
  localparam int ack_timeout = 64;

  // Query fields stay zero on update rows and update fields on query rows
  typedef struct packed {
    logic                       is_qry;
    logic                       overlap;
    sorted_lists_pkg::upd_cmd_t upd;
    sorted_lists_pkg::qry_cmd_t qry;
    sorted_lists_pkg::upd_rsp_t exp_upd;
    sorted_lists_pkg::qry_rsp_t exp_qry;
    logic                       exp_ntf;
    sorted_lists_pkg::ntf_t     exp_ntf_val;
  } row_t;

  logic                       clk;
  logic                       rst;
  logic                       upd_req;
  sorted_lists_pkg::upd_cmd_t upd_cmd;
  logic                       upd_ack;
  sorted_lists_pkg::upd_rsp_t upd_rsp;
  logic                       qry_req;
  sorted_lists_pkg::qry_cmd_t qry_cmd;
  logic                       qry_ack;
  sorted_lists_pkg::qry_rsp_t qry_rsp;
  logic                       ntf_vld;
  sorted_lists_pkg::ntf_t     ntf;

  row_t  rows[$];
  string names[$];
  int    rows_pass;
  int    rows_fail;
  int    errors;
  int    ntf_seen;
  int    ntf_expected;
  logic  stuck;

  sorted_lists dut0 (
    .clk     (clk),
    .rst     (rst),
    .upd_req (upd_req),
    .upd_cmd (upd_cmd),
    .upd_ack (upd_ack),
    .upd_rsp (upd_rsp),
    .qry_req (qry_req),
    .qry_cmd (qry_cmd),
    .qry_ack (qry_ack),
    .qry_rsp (qry_rsp),
    .ntf_vld (ntf_vld),
    .ntf     (ntf)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Counts every notification pulse whether expected or not
  always @(negedge clk) begin
    if (!rst && ntf_vld) begin
      ntf_seen++;
    end
  end

  function automatic void upd_row(string name, sorted_lists_pkg::id_t id,
                                  sorted_lists_pkg::op_t op, logic [15:0] key,
                                  logic [15:0] size, logic err);
    row_t r;
    r = '0;
    r.upd.id  = id;
    r.upd.op  = op;
    r.upd.key = key;
    r.upd.size = size;
    r.exp_upd.error = err;
    rows.push_back(r);
    names.push_back(name);
  endfunction

  function automatic void qry_row(string name, sorted_lists_pkg::id_t id,
                                  sorted_lists_pkg::level_t level, logic err,
                                  logic [15:0] key, logic [15:0] size,
                                  sorted_lists_pkg::count_t count);
    row_t r;
    r = '0;
    r.is_qry = 1'b1;
    r.qry.id = id;
    r.qry.level = level;
    r.exp_qry.error = err;
    r.exp_qry.key = key;
    r.exp_qry.size = size;
    r.exp_qry.count = count;
    rows.push_back(r);
    names.push_back(name);
  endfunction

  // Marks the last update row as notifying with its own id
  function automatic void expect_ntf(logic [15:0] key, logic [15:0] size);
    row_t r;
    r = rows.pop_back();
    r.exp_ntf = 1'b1;
    r.exp_ntf_val.id = r.upd.id;
    r.exp_ntf_val.key = key;
    r.exp_ntf_val.size = size;
    rows.push_back(r);
  endfunction

  // Last update row runs together with the next query row
  function automatic void overlap_next();
    row_t r;
    r = rows.pop_back();
    r.overlap = 1'b1;
    rows.push_back(r);
  endfunction

  task automatic build_rows();
    // List 0 is never written and stays empty after the reset sweep
    qry_row("qry_0_fresh", 3'd0, 3'd0, 1'b1, 16'h0000, 16'h0000, 3'd0);
    // Keys out of order
    upd_row("add_1_k30", 3'd1, sorted_lists_pkg::op_add, 16'h0030, 16'h0300, 1'b0);
    upd_row("add_1_k10", 3'd1, sorted_lists_pkg::op_add, 16'h0010, 16'h0100, 1'b0);
    upd_row("add_1_k40", 3'd1, sorted_lists_pkg::op_add, 16'h0040, 16'h0400, 1'b0);
    upd_row("add_1_k20", 3'd1, sorted_lists_pkg::op_add, 16'h0020, 16'h0200, 1'b0);
    qry_row("qry_1_l0", 3'd1, 3'd0, 1'b0, 16'h0010, 16'h0100, 3'd4);
    qry_row("qry_1_l1", 3'd1, 3'd1, 1'b0, 16'h0020, 16'h0200, 3'd4);
    qry_row("qry_1_l2", 3'd1, 3'd2, 1'b0, 16'h0030, 16'h0300, 3'd4);
    qry_row("qry_1_l3", 3'd1, 3'd3, 1'b0, 16'h0040, 16'h0400, 3'd4);
    qry_row("qry_1_l4", 3'd1, 3'd4, 1'b1, 16'h0000, 16'h0000, 3'd4);
    // Fifth add bounces off a full list
    upd_row("add_1_full", 3'd1, sorted_lists_pkg::op_add, 16'h0050, 16'h0500, 1'b1);
    qry_row("qry_1_l3_full", 3'd1, 3'd3, 1'b0, 16'h0040, 16'h0400, 3'd4);
    qry_row("qry_1_l7", 3'd1, 3'd7, 1'b1, 16'h0000, 16'h0000, 3'd4);
    // Second list beside the first
    upd_row("add_2_k05", 3'd2, sorted_lists_pkg::op_add, 16'h0005, 16'h0055, 1'b0);
    upd_row("add_2_k03", 3'd2, sorted_lists_pkg::op_add, 16'h0003, 16'h0033, 1'b0);
    qry_row("qry_2_l1", 3'd2, 3'd1, 1'b0, 16'h0005, 16'h0055, 3'd2);
    qry_row("qry_2_l2", 3'd2, 3'd2, 1'b1, 16'h0000, 16'h0000, 3'd2);
    qry_row("qry_1_l0_indep", 3'd1, 3'd0, 1'b0, 16'h0010, 16'h0100, 3'd4);
    // Replace touches one size only
    upd_row("rep_1_k20", 3'd1, sorted_lists_pkg::op_replace, 16'h0020, 16'h0222, 1'b0);
    qry_row("qry_1_l1_rep", 3'd1, 3'd1, 1'b0, 16'h0020, 16'h0222, 3'd4);
    qry_row("qry_1_l2_rep", 3'd1, 3'd2, 1'b0, 16'h0030, 16'h0300, 3'd4);
    upd_row("rep_1_absent", 3'd1, sorted_lists_pkg::op_replace, 16'h0025, 16'h0999, 1'b1);
    upd_row("del_1_absent", 3'd1, sorted_lists_pkg::op_delete, 16'h0025, 16'h0000, 1'b1);
    qry_row("qry_1_l1_unch", 3'd1, 3'd1, 1'b0, 16'h0020, 16'h0222, 3'd4);
    qry_row("qry_1_l3_unch", 3'd1, 3'd3, 1'b0, 16'h0040, 16'h0400, 3'd4);
    // Draining list 1 notifies only on the last delete
    upd_row("del_1_k30", 3'd1, sorted_lists_pkg::op_delete, 16'h0030, 16'h0000, 1'b0);
    qry_row("qry_1_l2_del", 3'd1, 3'd2, 1'b0, 16'h0040, 16'h0400, 3'd3);
    upd_row("del_1_k10", 3'd1, sorted_lists_pkg::op_delete, 16'h0010, 16'h0000, 1'b0);
    upd_row("del_1_k40", 3'd1, sorted_lists_pkg::op_delete, 16'h0040, 16'h0000, 1'b0);
    qry_row("qry_1_l0_last", 3'd1, 3'd0, 1'b0, 16'h0020, 16'h0222, 3'd1);
    upd_row("del_1_k20", 3'd1, sorted_lists_pkg::op_delete, 16'h0020, 16'h0000, 1'b0);
    expect_ntf(16'h0020, 16'h0222);
    qry_row("qry_1_l0_empty", 3'd1, 3'd0, 1'b1, 16'h0000, 16'h0000, 3'd0);
    upd_row("del_1_empty", 3'd1, sorted_lists_pkg::op_delete, 16'h0020, 16'h0000, 1'b1);
    qry_row("qry_2_l0_indep", 3'd2, 3'd0, 1'b0, 16'h0003, 16'h0033, 3'd2);
    // Clear notifies with a zero pair even on an empty list
    upd_row("clr_3_empty", 3'd3, sorted_lists_pkg::op_clear, 16'h7777, 16'h1111, 1'b0);
    expect_ntf(16'h0000, 16'h0000);
    qry_row("qry_3_l0", 3'd3, 3'd0, 1'b1, 16'h0000, 16'h0000, 3'd0);
    upd_row("clr_2", 3'd2, sorted_lists_pkg::op_clear, 16'h0000, 16'h0000, 1'b0);
    expect_ntf(16'h0000, 16'h0000);
    qry_row("qry_2_l0_clr", 3'd2, 3'd0, 1'b1, 16'h0000, 16'h0000, 3'd0);
    // Update and query in flight together on different ids
    upd_row("add_4_k09", 3'd4, sorted_lists_pkg::op_add, 16'h0009, 16'h0090, 1'b0);
    upd_row("ovl_add_5", 3'd5, sorted_lists_pkg::op_add, 16'h1234, 16'habcd, 1'b0);
    overlap_next();
    qry_row("ovl_qry_4", 3'd4, 3'd0, 1'b0, 16'h0009, 16'h0090, 3'd1);
    upd_row("ovl_add_4", 3'd4, sorted_lists_pkg::op_add, 16'h0001, 16'h0011, 1'b0);
    overlap_next();
    qry_row("ovl_qry_5", 3'd5, 3'd0, 1'b0, 16'h1234, 16'habcd, 3'd1);
    upd_row("ovl_clr_5", 3'd5, sorted_lists_pkg::op_clear, 16'h0000, 16'h0000, 1'b0);
    expect_ntf(16'h0000, 16'h0000);
    overlap_next();
    qry_row("ovl_qry_4_l0", 3'd4, 3'd0, 1'b0, 16'h0001, 16'h0011, 3'd2);
    qry_row("qry_4_l1", 3'd4, 3'd1, 1'b0, 16'h0009, 16'h0090, 3'd2);
    qry_row("qry_5_l0", 3'd5, 3'd0, 1'b1, 16'h0000, 16'h0000, 3'd0);
  endtask

  task automatic check(input string test, input string field, input logic [63:0] expected,
                       input logic [63:0] actual, inout int fails);
    if (expected !== actual) begin
      $display("Mismatch %s %s: expected 0x%0h, actual 0x%0h", test, field, expected, actual);
      fails++;
    end
  endtask

  // Four-phase update with ntf sampled in the first ack cycle
  task automatic send_update(input string test, input sorted_lists_pkg::upd_cmd_t cmd,
                             output sorted_lists_pkg::upd_rsp_t rsp, output logic got_ntf,
                             output sorted_lists_pkg::ntf_t ntf_val, output logic ok);
    int n;
    ok = 1'b0;
    rsp = '0;
    got_ntf = 1'b0;
    ntf_val = '0;
    @(negedge clk);
    upd_cmd = cmd;
    upd_req = 1'b1;
    n = 0;
    while (!upd_ack && n < ack_timeout) begin
      @(negedge clk);
      n++;
    end
    if (upd_ack) begin
      rsp = upd_rsp;
      got_ntf = ntf_vld;
      ntf_val = ntf;
      upd_req = 1'b0;
      n = 0;
      while (upd_ack && n < ack_timeout) begin
        @(negedge clk);
        n++;
      end
      ok = !upd_ack;
      if (!ok) begin
        $display("%s: update ack stayed high after req was dropped", test);
      end
    end else begin
      upd_req = 1'b0;
      $display("%s: no update ack within %0d cycles", test, ack_timeout);
    end
  endtask

  task automatic send_query(input string test, input sorted_lists_pkg::qry_cmd_t cmd,
                            output sorted_lists_pkg::qry_rsp_t rsp, output logic ok);
    int n;
    ok = 1'b0;
    rsp = '0;
    @(negedge clk);
    qry_cmd = cmd;
    qry_req = 1'b1;
    n = 0;
    while (!qry_ack && n < ack_timeout) begin
      @(negedge clk);
      n++;
    end
    if (qry_ack) begin
      rsp = qry_rsp;
      qry_req = 1'b0;
      n = 0;
      while (qry_ack && n < ack_timeout) begin
        @(negedge clk);
        n++;
      end
      ok = !qry_ack;
      if (!ok) begin
        $display("%s: query ack stayed high after req was dropped", test);
      end
    end else begin
      qry_req = 1'b0;
      $display("%s: no query ack within %0d cycles", test, ack_timeout);
    end
  endtask

  // Run one row and print its result line
  task automatic apply_row(input int i);
    row_t                       r;
    sorted_lists_pkg::upd_rsp_t ursp;
    sorted_lists_pkg::qry_rsp_t qrsp;
    sorted_lists_pkg::ntf_t     nval;
    logic                       got_ntf;
    logic                       ok;
    int                         fails;
    r = rows[i];
    fails = 0;
    if (r.is_qry) begin
      send_query(names[i], r.qry, qrsp, ok);
      if (ok) begin
        check(names[i], "error", 64'(r.exp_qry.error), 64'(qrsp.error), fails);
        check(names[i], "count", 64'(r.exp_qry.count), 64'(qrsp.count), fails);
        check(names[i], "key", 64'(r.exp_qry.key), 64'(qrsp.key), fails);
        check(names[i], "size", 64'(r.exp_qry.size), 64'(qrsp.size), fails);
      end
    end else begin
      ntf_expected += int'(r.exp_ntf);
      send_update(names[i], r.upd, ursp, got_ntf, nval, ok);
      if (ok) begin
        check(names[i], "error", 64'(r.exp_upd.error), 64'(ursp.error), fails);
        check(names[i], "ntf_vld", 64'(r.exp_ntf), 64'(got_ntf), fails);
        if (r.exp_ntf && got_ntf) begin
          check(names[i], "ntf", 64'(r.exp_ntf_val), 64'(nval), fails);
        end
      end
    end
    if (!ok) begin
      fails++;
      stuck = 1'b1;
    end
    errors += fails;
    if (fails == 0) begin
      rows_pass++;
      $display("PASS %s", names[i]);
    end else begin
      rows_fail++;
      $display("FAIL %s", names[i]);
    end
  endtask

  initial begin
    int gap;
    int i;
    int fails;
    void'($urandom(32'h76db_844e));
    rst = 1'b1;
    upd_req = 1'b0;
    upd_cmd = '0;
    qry_req = 1'b0;
    qry_cmd = '0;
    rows_pass = 0;
    rows_fail = 0;
    errors = 0;
    ntf_seen = 0;
    ntf_expected = 0;
    stuck = 1'b0;
    build_rows();
    repeat (4) @(negedge clk);
    rst = 1'b0;

    i = 0;
    while (i < rows.size() && !stuck) begin
      // Idle gap before each command or overlapped pair
      gap = int'($urandom % 4);
      repeat (gap) @(negedge clk);
      if (rows[i].overlap && (i + 1 < rows.size())) begin
        fork
          apply_row(i);
          apply_row(i + 1);
        join
        i += 2;
      end else begin
        apply_row(i);
        i++;
      end
    end

    // Catches a notification outside any expected update
    fails = 0;
    if (!stuck) begin
      repeat (2) @(negedge clk);
      check("ntf_total", "pulses", 64'(ntf_expected), 64'(ntf_seen), fails);
    end
    errors += fails;
    $display("Rows %0d of %0d run, %0d passed, %0d failed, %0d errors",
             rows_pass + rows_fail, rows.size(), rows_pass, rows_fail, errors);
    if (errors == 0 && !stuck && rows_pass == rows.size()) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
